//--- project.f
+incdir+tests
source/gat_pkg.sv
source/feature_fifo.sv
source/neighbor_aggregator.sv
source/feature_controller.sv
source/feature_bram.sv
source/gat_sequencer.sv
source/gat_output_stage.sv
tests/tb_gat_output_stage.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_gat_output_stage -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_gat_model.svh
// LFSR random source, reference aggregation model and value check task
`ifndef TB_GAT_MODEL_SVH
`define TB_GAT_MODEL_SVH

// ====================
// Random source
// ====================
logic [31:0] lfsr_state;

// Galois form with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

// Alpha in 0 .. 1.0
function automatic logic [ALPHA_DATA_WIDTH-1:0] rand_alpha();
  logic [31:0] a;
  a = rand_bits(ALPHA_DATA_WIDTH);
  if (a > 32768) begin
    a = a - 32768;
  end
  return a[ALPHA_DATA_WIDTH-1:0];
endfunction

// ====================
// Reference model
// ====================
longint      model_acc [NUM_FEATURE_OUT];
logic [31:0] exp_mem   [NEW_FEATURE_DEPTH];
int          check_cnt;
int          err_cnt;

task automatic model_clear();
  for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
    model_acc[l] = 0;
  end
endtask

// Sums alpha * WH per lane and floor-shifts by the alpha fraction at the last entry
task automatic model_entry(input int node,
                           input logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh,
                           input logic [ALPHA_DATA_WIDTH-1:0] alpha, input logic last);
  longint w;
  longint a;
  for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
    w = longint'($signed(wh[l]));
    a = longint'(alpha);
    model_acc[l] += w * a;
  end
  if (last) begin
    // Word j of a node holds its lane 3-j
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      exp_mem[node * NUM_FEATURE_OUT + j] =
        32'(model_acc[NUM_FEATURE_OUT - 1 - j] >>> ALPHA_FRAC_BITS);
    end
    model_clear();
  end
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  check_cnt++;
  if (actual !== expected) begin
    err_cnt++;
    $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
  end
endtask

`endif

//--- tests/tb_gat_output_stage.sv
// Testbench top for the GAT output stage with random runs, readback and timeout
`timescale 1ns/1ps

module tb_gat_output_stage
  import gat_pkg::*;
();

  localparam int CLK_PERIOD     = 20;
  // Eight worst-case runs at four cycles per entry plus margin
  localparam int TIMEOUT_CYCLES = 8 * NUM_SUBGRAPHS * MAX_NEIGHBORS * 4 + 1000;

  logic                                          clk;
  logic                                          rst_n;
  logic                                          start;
  logic                                          nbr_vld;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] nbr_wh;
  logic [ALPHA_DATA_WIDTH-1:0]                   nbr_alpha;
  logic                                          nbr_last;
  logic [NEW_FEATURE_ADDR_W-1:0]                 rd_addr;
  logic                                          nbr_rdy;
  logic                                          gat_ready;
  logic [NEW_FEATURE_WIDTH-1:0]                  rd_data;
  int                                            cycle_cnt;
  int                                            test_cnt;
  int                                            test_err_base;

  `include "tb_gat_model.svh"

  gat_output_stage gat_output_stage_i (
    .clk (clk), .rst_n (rst_n), .start (start),
    .nbr_vld (nbr_vld), .nbr_wh (nbr_wh), .nbr_alpha (nbr_alpha), .nbr_last (nbr_last),
    .rd_addr (rd_addr), .nbr_rdy (nbr_rdy), .gat_ready (gat_ready), .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ====================
  // Stimulus helpers
  // ====================
  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    step();
    start = 1'b0;
  endtask

  // Holds the entry until an edge sees nbr_rdy high
  task automatic send_entry(input logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh,
                            input logic [ALPHA_DATA_WIDTH-1:0] alpha, input logic last);
    logic taken;
    nbr_vld   = 1'b1;
    nbr_wh    = wh;
    nbr_alpha = alpha;
    nbr_last  = last;
    do begin
      taken = nbr_rdy;
      step();
    end while (!taken);
    nbr_vld = 1'b0;
  endtask

  task automatic run_nodes(input bit gaps, input bit single);
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh;
    logic [ALPHA_DATA_WIDTH-1:0]                   alpha;
    int                                            n_nbrs;
    for (int n = 0; n < NUM_SUBGRAPHS; n++) begin
      n_nbrs = single ? 1 : int'(rand_bits($clog2(MAX_NEIGHBORS))) + 1;
      for (int k = 0; k < n_nbrs; k++) begin
        for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
          wh[l] = WH_DATA_WIDTH'(rand_bits(WH_DATA_WIDTH));
        end
        alpha = rand_alpha();
        model_entry(n, wh, alpha, k == n_nbrs - 1);
        if (gaps) begin
          repeat (rand_bits(2)) step();
        end
        send_entry(wh, alpha, k == n_nbrs - 1);
      end
    end
  endtask

  task automatic wait_done();
    while (!gat_ready) begin
      step();
    end
  endtask

  // Pipelined readback where rd_data trails rd_addr by one edge
  task automatic read_back();
    rd_addr = '0;
    step();
    for (int a = 0; a < NEW_FEATURE_DEPTH; a++) begin
      check_value($sformatf("rd_data[%0d]", a), rd_data, exp_mem[a]);
      rd_addr = NEW_FEATURE_ADDR_W'(a + 1);
      step();
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("%-14s %s, %0d errors", name,
             (err_cnt == test_err_base) ? "passed" : "failed", err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    lfsr_state    = 32'h0c9fca62;
    cycle_cnt     = 0;
    check_cnt     = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_err_base = 0;
    rst_n         = 1'b0;
    start         = 1'b0;
    nbr_vld       = 1'b0;
    nbr_wh        = '0;
    nbr_alpha     = '0;
    nbr_last      = 1'b0;
    rd_addr       = '0;
    model_clear();
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step();

    check_value("nbr_rdy", nbr_rdy, 0);
    check_value("gat_ready", gat_ready, 0);
    pulse_start();
    check_value("nbr_rdy", nbr_rdy, 1);
    finish_test("reset");

    // Random neighbor counts and idle gaps
    run_nodes(1'b1, 1'b0);
    check_value("nbr_rdy", nbr_rdy, 0);
    wait_done();
    read_back();
    finish_test("full_run");

    // Back-to-back single entries fill the FIFO
    pulse_start();
    run_nodes(1'b0, 1'b1);
    wait_done();
    read_back();
    finish_test("back_pressure");

    // Entries offered after done must be ignored
    check_value("gat_ready", gat_ready, 1);
    for (int i = 0; i < 6; i++) begin
      nbr_vld = (i % 2 == 0);
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        nbr_wh[l] = WH_DATA_WIDTH'(rand_bits(WH_DATA_WIDTH));
      end
      nbr_alpha = rand_alpha();
      nbr_last  = 1'b1;
      check_value("nbr_rdy", nbr_rdy, 0);
      step();
    end
    nbr_vld = 1'b0;
    repeat (3) step();
    read_back();
    finish_test("done_hold");

    pulse_start();
    check_value("gat_ready", gat_ready, 0);
    run_nodes(1'b1, 1'b0);
    wait_done();
    read_back();
    finish_test("rerun");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- source/gat_output_stage.sv
// GAT output stage top with sequencer, aggregator, controller and feature memory
`timescale 1ns/1ps

module gat_output_stage
  import gat_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          start,
  input  logic                                          nbr_vld,
  input  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] nbr_wh,
  input  logic [ALPHA_DATA_WIDTH-1:0]                   nbr_alpha,
  input  logic                                          nbr_last,
  input  logic [NEW_FEATURE_ADDR_W-1:0]                 rd_addr,
  output logic                                          nbr_rdy,
  output logic                                          gat_ready,
  output logic [NEW_FEATURE_WIDTH-1:0]                  rd_data
);

  logic                                              nbr_take;
  logic                                              clear;
  logic                                              space_avail;
  logic                                              vec_written;
  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] new_feat;
  logic                                              new_feat_vld;
  logic [NEW_FEATURE_ADDR_W-1:0]                     feat_bram_addra;
  logic [NEW_FEATURE_WIDTH-1:0]                      feat_bram_din;
  logic                                              feat_bram_ena;

  gat_sequencer u_sequencer (
    .clk (clk), .rst_n (rst_n),
    .start (start), .nbr_vld (nbr_vld), .nbr_last (nbr_last),
    .space_avail (space_avail), .vec_written (vec_written),
    .nbr_rdy (nbr_rdy), .nbr_take (nbr_take), .clear (clear), .gat_ready (gat_ready)
  );

  neighbor_aggregator u_aggregator (
    .clk (clk), .rst_n (rst_n),
    .nbr_take (nbr_take), .nbr_wh (nbr_wh), .nbr_alpha (nbr_alpha), .nbr_last (nbr_last),
    .new_feat (new_feat), .new_feat_vld (new_feat_vld)
  );

  feature_controller u_controller (
    .clk (clk), .rst_n (rst_n), .clear (clear),
    .new_feat (new_feat), .new_feat_vld (new_feat_vld),
    .space_avail (space_avail), .vec_written (vec_written),
    .feat_bram_addra (feat_bram_addra), .feat_bram_din (feat_bram_din),
    .feat_bram_ena (feat_bram_ena)
  );

  feature_bram u_bram (
    .clk (clk), .ena (feat_bram_ena), .addra (feat_bram_addra), .dina (feat_bram_din),
    .addrb (rd_addr), .doutb (rd_data)
  );

endmodule

//--- source/gat_sequencer.sv
// Run control FSM with acceptance gating, vector counting and done level
`timescale 1ns/1ps

module gat_sequencer
  import gat_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic nbr_vld,
  input  logic nbr_last,
  input  logic space_avail,
  input  logic vec_written,
  output logic nbr_rdy,
  output logic nbr_take,
  output logic clear,
  output logic gat_ready
);

  seq_state_e              state;
  seq_state_e              state_nxt;
  logic [NODE_CNT_WIDTH-1:0] node_cnt;
  logic [NODE_CNT_WIDTH-1:0] vec_cnt;
  logic                      run_start;

  // Start is ignored while a run is active
  assign run_start = start && (state != SEQ_RUN);

  always_comb begin
    state_nxt = state;
    case (state)
      SEQ_IDLE: if (start) state_nxt = SEQ_RUN;
      SEQ_RUN:  if (vec_written && vec_cnt == NODE_CNT_WIDTH'(NUM_SUBGRAPHS - 1)) begin
        state_nxt = SEQ_DONE;
      end
      SEQ_DONE: if (start) state_nxt = SEQ_RUN;
      default:  state_nxt = SEQ_IDLE;
    endcase
  end

  // Accept only while running, nodes remain and the FIFO has room
  assign nbr_rdy   = (state == SEQ_RUN) && (node_cnt < NODE_CNT_WIDTH'(NUM_SUBGRAPHS)) &&
                     space_avail;
  assign nbr_take  = nbr_vld && nbr_rdy;
  assign gat_ready = (state == SEQ_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= SEQ_IDLE;
      node_cnt <= '0;
      vec_cnt  <= '0;
      clear    <= 1'b0;
    end else begin
      state <= state_nxt;
      clear <= run_start;
      if (run_start) begin
        node_cnt <= '0;
        vec_cnt  <= '0;
      end else begin
        if (nbr_take && nbr_last) node_cnt <= node_cnt + 1'b1;
        if (vec_written)          vec_cnt  <= vec_cnt + 1'b1;
      end
    end
  end

  // Memory writes only happen as part of a run
  a_no_write_idle: assert property (
    @(posedge clk) disable iff (!rst_n) vec_written |-> (state != SEQ_IDLE)
  );

endmodule

//--- source/feature_bram.sv
// Feature memory with one write port and one registered read port
`timescale 1ns/1ps

module feature_bram
  import gat_pkg::*;
(
  input  logic                          clk,
  input  logic                          ena,
  input  logic [NEW_FEATURE_ADDR_W-1:0] addra,
  input  logic [NEW_FEATURE_WIDTH-1:0]  dina,
  input  logic [NEW_FEATURE_ADDR_W-1:0] addrb,
  output logic [NEW_FEATURE_WIDTH-1:0]  doutb
);

  logic [NEW_FEATURE_WIDTH-1:0] mem [NEW_FEATURE_DEPTH];

  // Port A write
  always_ff @(posedge clk) begin
    if (ena) begin
      mem[addra] <= dina;
    end
  end

  // Port B read with one cycle latency
  always_ff @(posedge clk) begin
    doutb <= mem[addrb];
  end

endmodule

//--- source/feature_controller.sv
// Vector buffering and element-wise serialization into the feature memory
`timescale 1ns/1ps

module feature_controller
  import gat_pkg::*;
(
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              clear,
  input  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] new_feat,
  input  logic                                              new_feat_vld,
  output logic                                              space_avail,
  output logic                                              vec_written,
  output logic [NEW_FEATURE_ADDR_W-1:0]                     feat_bram_addra,
  output logic [NEW_FEATURE_WIDTH-1:0]                      feat_bram_din,
  output logic                                              feat_bram_ena
);

  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] ff_dout;
  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] feat;
  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] feat_reg;
  logic                                              ff_rd_vld;
  logic                                              ff_empty;
  logic                                              ff_full;
  logic [$clog2(FEAT_FIFO_DEPTH+1)-1:0]              ff_count;
  logic [CNT_WIDTH-1:0]                              cnt_reg;
  logic [CNT_WIDTH-1:0]                              lane_idx;

  feature_fifo #(
    .DATA_WIDTH (NUM_FEATURE_OUT * NEW_FEATURE_WIDTH),
    .FIFO_DEPTH (FEAT_FIFO_DEPTH)
  ) u_feat_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (new_feat),
    .wr_vld (new_feat_vld),
    .rd_vld (ff_rd_vld),
    .dout   (ff_dout),
    .empty  (ff_empty),
    .full   (ff_full),
    .count  (ff_count)
  );

  // Two free slots leave room for a result still in the aggregator
  assign space_avail = (ff_count <= FEAT_FIFO_DEPTH - 2);

  // ====================
  // Pop and serialize
  // ====================
  assign ff_rd_vld     = (cnt_reg == '0) && !ff_empty;
  assign feat          = ff_rd_vld ? ff_dout : feat_reg;
  assign feat_bram_ena = ff_rd_vld || (cnt_reg != '0);
  assign vec_written   = feat_bram_ena && (cnt_reg == CNT_WIDTH'(NUM_FEATURE_OUT - 1));

  // Highest lane goes out first
  assign lane_idx      = CNT_WIDTH'(NUM_FEATURE_OUT - 1) - cnt_reg;
  assign feat_bram_din = feat[lane_idx];

  always_ff @(posedge clk) begin
    if (ff_rd_vld) begin
      feat_reg <= ff_dout;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_reg         <= '0;
      feat_bram_addra <= '0;
    end else begin
      if (feat_bram_ena) begin
        cnt_reg <= vec_written ? '0 : cnt_reg + 1'b1;
      end
      // New run restarts at address 0
      if (clear) begin
        feat_bram_addra <= '0;
      end else if (feat_bram_ena) begin
        feat_bram_addra <= feat_bram_addra + 1'b1;
      end
    end
  end

  // Back-pressure upstream must keep the FIFO from overflowing
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) new_feat_vld |-> !ff_full
  );

endmodule

//--- source/neighbor_aggregator.sv
// Per-lane alpha times WH accumulation over the neighbors of one node
`timescale 1ns/1ps

module neighbor_aggregator
  import gat_pkg::*;
(
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              nbr_take,
  input  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0]     nbr_wh,
  input  logic [ALPHA_DATA_WIDTH-1:0]                       nbr_alpha,
  input  logic                                              nbr_last,
  output logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] new_feat,
  output logic                                              new_feat_vld
);

  logic signed [NEW_FEATURE_WIDTH-1:0] acc  [NUM_FEATURE_OUT];
  logic signed [NEW_FEATURE_WIDTH-1:0] prod [NUM_FEATURE_OUT];
  logic signed [NEW_FEATURE_WIDTH-1:0] sum  [NUM_FEATURE_OUT];
  logic [$clog2(MAX_NEIGHBORS+1)-1:0]  nbr_cnt;

  // ====================
  // Lane arithmetic
  // ====================
  // Alpha is zero-extended so the product stays signed
  always_comb begin
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      prod[i] = $signed(nbr_wh[i]) * $signed({1'b0, nbr_alpha});
      sum[i]  = acc[i] + prod[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        acc[i] <= '0;
      end
      new_feat_vld <= 1'b0;
      nbr_cnt      <= '0;
    end else begin
      new_feat_vld <= nbr_take && nbr_last;
      if (nbr_take) begin
        for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
          acc[i] <= nbr_last ? '0 : sum[i];
        end
        nbr_cnt <= nbr_last ? '0 : nbr_cnt + 1'b1;
      end
    end
  end

  // Arithmetic shift drops the alpha fraction, rounding toward minus infinity
  always_ff @(posedge clk) begin
    if (nbr_take && nbr_last) begin
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        new_feat[i] <= sum[i] >>> ALPHA_FRAC_BITS;
      end
    end
  end

  // Neighbor lists are bounded per node
  a_max_neighbors: assert property (
    @(posedge clk) disable iff (!rst_n) nbr_take |-> (nbr_cnt < MAX_NEIGHBORS)
  );

endmodule

//--- source/feature_fifo.sv
// Synchronous first-word-fall-through FIFO with occupancy count
`timescale 1ns/1ps

module feature_fifo #(
  parameter int DATA_WIDTH = 128,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [DATA_WIDTH-1:0]             din,
  input  logic                              wr_vld,
  input  logic                              rd_vld,
  output logic [DATA_WIDTH-1:0]             dout,
  output logic                              empty,
  output logic                              full,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]   count
);

  logic [DATA_WIDTH-1:0]         mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  logic                          do_wr;
  logic                          do_rd;

  assign empty = (count == 0);
  assign full  = (count == FIFO_DEPTH);
  assign do_wr = wr_vld && !full;
  assign do_rd = rd_vld && !empty;

  // Head word is visible without a read request
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Reader must only pop a word that is there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) rd_vld |-> !empty);

endmodule

//--- source/gat_pkg.sv
// Sizes, fixed-point format and sequencer state type for the GAT output stage
package gat_pkg;

  // ====================
  // Graph and vector sizes
  // ====================
  localparam int NUM_FEATURE_OUT   = 4;
  localparam int NUM_SUBGRAPHS     = 8;
  localparam int MAX_NEIGHBORS     = 8;

  // ====================
  // Data formats
  // ====================
  // WH lanes are signed and alpha is unsigned Q1.15
  localparam int WH_DATA_WIDTH     = 12;
  localparam int ALPHA_DATA_WIDTH  = 16;
  localparam int ALPHA_FRAC_BITS   = 15;
  // Output elements and accumulators share one width
  localparam int NEW_FEATURE_WIDTH = 32;

  // ====================
  // Buffering and memory
  // ====================
  localparam int FEAT_FIFO_DEPTH    = 4;
  localparam int NEW_FEATURE_DEPTH  = NUM_SUBGRAPHS * NUM_FEATURE_OUT;
  localparam int NEW_FEATURE_ADDR_W = 5;

  // Counter widths
  localparam int CNT_WIDTH      = 2;
  localparam int NODE_CNT_WIDTH = 4;

  // Sequencer FSM states
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_DONE} seq_state_e;

endpackage
